// File: l2_request_path.f
verilog/l2_config_pkg.sv
verilog/l2_types_pkg.sv
verilog/l2_queue_if.sv
verilog/sync_fifo.sv
verilog/l2_request_arbiter.sv
verilog/l2_request_path.sv
tests/l2_request_checker.sv
tests/l2_request_path_tb.sv

// File: Makefile
# Verilator build and run of the L2 request path testbench
VERILATOR ?= verilator
TOP ?= l2_request_path_tb
FILELIST ?= l2_request_path.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/l2_request_path_tb.sv
// Seeded random traffic from two cores; a lost request shows up as a drain timeout
`timescale 1ns/10ps
`default_nettype none

module l2_request_path_tb;
	import l2_config_pkg::*;
	import l2_types_pkg::*;

	// Enqueue attempts per port, the share of them run with memory always ready,
	// and the cycle limit as a multiple of the attempt count
	localparam int NUM_TRANS = 2000;
	localparam int FAIR_TRANS = 200;
	localparam int TIMEOUT_FACTOR = 8;
	localparam int CYCLE_LIMIT = TIMEOUT_FACTOR * NUM_TRANS;

	// The clock starts high so the first falling edge comes before the first rising edge
	logic clk = 1'b1;
	logic reset;
	logic [NUM_PORTS - 1:0] port_enqueue;
	l2_addr_t port_addr[NUM_PORTS];
	l2_data_t port_data[NUM_PORTS];
	logic [NUM_PORTS - 1:0] port_store;
	logic [NUM_PORTS - 1:0] port_flush;
	logic [NUM_PORTS - 1:0] port_stall;
	logic mem_ready;
	logic mem_request;
	l2_addr_t mem_addr;
	l2_data_t mem_data;
	logic mem_store;
	l2_port_t mem_port;
	int error_count;
	int pending;
	integer seed;
	int attempts[NUM_PORTS];
	int cycle_count = 0;

	l2_request_path UUT (.*);
	l2_request_checker request_checker (.*);

	initial
	begin
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timed out after %0d cycles with %0d requests outstanding", CYCLE_LIMIT,
				pending);
			$display("TB FAILED");
			$finish;
		end
	end

	// One falling-edge step of core and memory stimulus
	// Enqueue odds are out of four
	// Flushes only come while memory is held off
	task automatic drive_cycle(input logic ready, input int enqueue_odds, input bit allow_flush);
		@(negedge clk);
		mem_ready = ready;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			port_enqueue[p] = 1'b0;
			port_flush[p] = 1'b0;
			if (allow_flush && !ready && ($random(seed) & 63) == 0)
				port_flush[p] = 1'b1;
			else if (attempts[p] < NUM_TRANS && ($random(seed) & 3) < enqueue_odds)
			begin
				// A stalled core drops its attempt, as the pipeline would replay it later
				attempts[p]++;
				if (!port_stall[p])
				begin
					port_enqueue[p] = 1'b1;
					port_addr[p] = l2_addr_t'($random(seed));
					port_data[p] = l2_data_t'($random(seed));
					port_store[p] = ($random(seed) & 1) != 0;
				end
			end
		end
	endtask

	initial
	begin
		logic ready;

		seed = 32'h771a_a7f2;
		reset = 1'b0;
		port_enqueue = '0;
		port_store = '0;
		port_flush = '0;
		mem_ready = 1'b0;
		ready = 1'b0;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			port_addr[p] = '0;
			port_data[p] = '0;
			attempts[p] = 0;
		end

		// Reset rises on the first falling edge and spans three rising edges
		@(negedge clk);
		reset = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		// Both cores push every cycle against a ready memory, so grants must alternate
		while (attempts[0] < FAIR_TRANS || attempts[1] < FAIR_TRANS)
			drive_cycle(1'b1, 4, 1'b0);

		// Long random stretches of back-pressure with flushes inside them
		while (attempts[0] < NUM_TRANS || attempts[1] < NUM_TRANS)
		begin
			if (($random(seed) & 7) == 0)
				ready = !ready;
			drive_cycle(ready, 2, 1'b1);
		end

		// Drain with memory ready, then a few idle cycles to catch stray requests
		while (pending != 0)
			drive_cycle(1'b1, 0, 1'b0);
		repeat (4) drive_cycle(1'b1, 0, 1'b0);

		$display("Run complete: %0d errors, %0d requests never issued", error_count, pending);
		if (error_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/l2_request_checker.sv
// Request path checker; exact only while cores obey port_stall and flush with mem_ready low
`timescale 1ns/10ps
`default_nettype none

module l2_request_checker
	(
		input wire clk,
		input wire reset,
		input wire [l2_config_pkg::NUM_PORTS - 1:0] port_enqueue,
		input wire l2_types_pkg::l2_addr_t port_addr[l2_config_pkg::NUM_PORTS],
		input wire l2_types_pkg::l2_data_t port_data[l2_config_pkg::NUM_PORTS],
		input wire [l2_config_pkg::NUM_PORTS - 1:0] port_store,
		input wire [l2_config_pkg::NUM_PORTS - 1:0] port_flush,
		input wire [l2_config_pkg::NUM_PORTS - 1:0] port_stall,
		input wire mem_ready,
		input wire mem_request,
		input wire l2_types_pkg::l2_addr_t mem_addr,
		input wire l2_types_pkg::l2_data_t mem_data,
		input wire mem_store,
		input wire l2_types_pkg::l2_port_t mem_port,
		output int error_count,
		output int pending
	);

	import l2_config_pkg::*;
	import l2_types_pkg::*;

	// Accepted requests per port that have not yet shown up on the memory side
	queue_entry_t model_q[NUM_PORTS][$];

	// Queue loading and mem_ready as the arbiter saw them at the previous edge
	logic [NUM_PORTS - 1:0] loaded_at_grant;
	logic ready_at_grant;
	l2_port_t last_port;
	int errors = 0;
	int pending_count = 0;

	assign error_count = errors;
	assign pending = pending_count;

	// Outputs read here belong to the cycle that this edge closes
	always @(posedge clk)
	begin
		queue_entry_t seen;
		queue_entry_t want;
		logic expect_request;
		l2_port_t next_port;
		l2_port_t expect_port;

		if (reset)
		begin
			if (mem_request !== 1'b0 || port_stall !== '0)
			begin
				errors++;
				$display("[FAIL] %0t: mem_request or port_stall high during reset", $time);
			end
			for (int p = 0; p < NUM_PORTS; p++)
				model_q[p].delete();
			loaded_at_grant = '0;
			ready_at_grant = 1'b0;
			// Pointing at the last port means port 0 wins first
			last_port = l2_port_t'(NUM_PORTS - 1);
		end
		else
		begin
			// A request is due whenever memory was ready and any queue held work
			expect_request = ready_at_grant && loaded_at_grant != '0;
			if (mem_request !== expect_request)
			begin
				errors++;
				$display("[FAIL] %0t: mem_request is %b, expected %b", $time, mem_request,
					expect_request);
			end
			if (mem_request === 1'b1)
			begin
				// The other port has priority over the last winner when it has work
				next_port = l2_port_t'(last_port + 1'b1);
				expect_port = loaded_at_grant[next_port] ? next_port : last_port;
				if (expect_request && mem_port !== expect_port)
				begin
					errors++;
					$display("[FAIL] %0t: request from port %0d, round-robin expects %0d",
						$time, mem_port, expect_port);
				end
				last_port = mem_port;
				seen = {mem_addr, mem_data, mem_store};
				if (model_q[mem_port].size() == 0)
				begin
					errors++;
					$display("[FAIL] %0t: request %h on port %0d with nothing queued", $time,
						seen, mem_port);
				end
				else
				begin
					want = model_q[mem_port].pop_front();
					if (seen !== want)
					begin
						errors++;
						$display("[FAIL] %0t: port %0d issued %h, expected %h", $time, mem_port,
							seen, want);
					end
				end
			end

			// Model now matches the queues as they stand after the previous edge
			for (int p = 0; p < NUM_PORTS; p++)
			begin
				if (port_stall[p] !== (model_q[p].size() >= STALL_THRESHOLD))
				begin
					errors++;
					$display("[FAIL] %0t: port %0d stall is %b with %0d queued", $time, p,
						port_stall[p], model_q[p].size());
				end
				loaded_at_grant[p] = model_q[p].size() > 0;
			end
			ready_at_grant = mem_ready;

			// Flush wins over an enqueue at the same edge
			for (int p = 0; p < NUM_PORTS; p++)
			begin
				if (port_flush[p])
					model_q[p].delete();
				else if (port_enqueue[p])
					model_q[p].push_back({port_addr[p], port_data[p], port_store[p]});
			end
		end
		pending_count = model_q[0].size() + model_q[1].size();
	end

endmodule

`default_nettype wire

// File: verilog/l2_request_path.sv
// Request side of the shared L2; cores must not enqueue while port_stall is high, nothing here blocks them
`timescale 1ns/10ps
`default_nettype none

module l2_request_path
	(
		input wire clk,
		input wire reset,

		// Core side, one entry per requesting core
		input wire [l2_config_pkg::NUM_PORTS - 1:0] port_enqueue,
		input wire l2_types_pkg::l2_addr_t port_addr[l2_config_pkg::NUM_PORTS],
		input wire l2_types_pkg::l2_data_t port_data[l2_config_pkg::NUM_PORTS],
		input wire [l2_config_pkg::NUM_PORTS - 1:0] port_store,
		input wire [l2_config_pkg::NUM_PORTS - 1:0] port_flush,
		output wire [l2_config_pkg::NUM_PORTS - 1:0] port_stall,

		// Memory side
		input wire mem_ready,
		output wire mem_request,
		output wire l2_types_pkg::l2_addr_t mem_addr,
		output wire l2_types_pkg::l2_data_t mem_data,
		output wire mem_store,
		output wire l2_types_pkg::l2_port_t mem_port
	);

	import l2_config_pkg::*;
	import l2_types_pkg::*;

	// One head view per queue, read by the arbiter
	l2_queue_if queue_bus[NUM_PORTS]();

	// Core requests packed into the stored entry format
	queue_entry_t enqueue_entry[NUM_PORTS];

	genvar i;
	generate
		for (i = 0; i < NUM_PORTS; i++)
		begin : g_port
			// Layout is {address, data, store}
			// The arbiter unpacks the same way
			assign enqueue_entry[i] = {port_addr[i], port_data[i], port_store[i]};

			// The stall level is the almost-full flag, so it tracks the count
			// in the same cycle and leaves room for the core pipeline
			sync_fifo #(
				.DATA_WIDTH($bits(queue_entry_t)),
				.NUM_ENTRIES(QUEUE_DEPTH),
				.ALMOST_FULL_THRESHOLD(STALL_THRESHOLD)
			) request_queue (
				.clk(clk),
				.reset(reset),
				.flush_en(port_flush[i]),
				.full(),
				.almost_full(port_stall[i]),
				.enqueue_en(port_enqueue[i]),
				.value_i(enqueue_entry[i]),
				.empty(queue_bus[i].empty),
				.almost_empty(),
				.dequeue_en(queue_bus[i].dequeue),
				.value_o(queue_bus[i].head)
			);
		end
	endgenerate

	// Picks one queue per cycle and registers the request
	l2_request_arbiter request_arbiter (
		.clk(clk),
		.reset(reset),
		.queues(queue_bus),
		.mem_ready(mem_ready),
		.mem_request(mem_request),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_store(mem_store),
		.mem_port(mem_port)
	);

endmodule

`default_nettype wire

// File: verilog/l2_request_arbiter.sv
// Round-robin over the request queues; one request per cycle while mem_ready is high, output registered
`timescale 1ns/10ps
`default_nettype none

module l2_request_arbiter
	(
		input wire clk,
		input wire reset,
		l2_queue_if.arbiter queues[l2_config_pkg::NUM_PORTS],
		input wire mem_ready,
		output logic mem_request,
		output l2_types_pkg::l2_addr_t mem_addr,
		output l2_types_pkg::l2_data_t mem_data,
		output logic mem_store,
		output l2_types_pkg::l2_port_t mem_port
	);

	import l2_config_pkg::*;
	import l2_types_pkg::*;

	// Queue state gathered into plain arrays that the grant port can index
	logic [NUM_PORTS - 1:0] queue_empty;
	queue_entry_t queue_head[NUM_PORTS];
	logic [NUM_PORTS - 1:0] queue_dequeue;

	// Port that won the last grant
	l2_port_t last_grant;

	// Result of this cycle's search
	logic grant_valid;
	l2_port_t grant_port;

	// Head of the winning queue, split into its fields
	l2_addr_t sel_addr;
	l2_data_t sel_data;
	logic sel_store;

	genvar i;
	generate
		for (i = 0; i < NUM_PORTS; i++)
		begin : g_queue
			assign queue_empty[i] = queues[i].empty;
			assign queue_head[i] = queues[i].head;

			// At most one queue is popped, and only on a valid grant
			assign queue_dequeue[i] = grant_valid && grant_port == l2_port_t'(i);
			assign queues[i].dequeue = queue_dequeue[i];
		end
	endgenerate

	// Search starts at the port after the last winner and ends with
	// the last winner itself
	always_comb
	begin
		int idx;

		grant_valid = 1'b0;
		grant_port = last_grant;
		for (int k = 1; k <= NUM_PORTS; k++)
		begin
			idx = (int'(last_grant) + k) % NUM_PORTS;
			if (mem_ready && !grant_valid && !queue_empty[idx])
			begin
				grant_valid = 1'b1;
				grant_port = l2_port_t'(idx);
			end
		end
	end

	// Unpack the winning head
	// The layout is {address, data, store}
	assign {sel_addr, sel_data, sel_store} = queue_head[grant_port];

	// Control state of the grant pointer and the request strobe
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Pointing at the last port makes port 0 the first choice
			last_grant <= l2_port_t'(NUM_PORTS - 1);
			mem_request <= 1'b0;
		end
		else
		begin
			mem_request <= grant_valid;
			if (grant_valid)
				last_grant <= grant_port;
		end
	end

	// Request fields are only meaningful while mem_request is high
	always_ff @(posedge clk)
	begin
		if (grant_valid)
		begin
			mem_addr <= sel_addr;
			mem_data <= sel_data;
			mem_store <= sel_store;
			mem_port <= grant_port;
		end
	end

endmodule

`default_nettype wire

// File: verilog/sync_fifo.sv
// Show-ahead FIFO; NUM_ENTRIES must be a power of two, and enqueue when full or dequeue when empty is not checked
`timescale 1ns/10ps
`default_nettype none

module sync_fifo
	#(
		parameter int DATA_WIDTH = 64,
		parameter int NUM_ENTRIES = 4,
		parameter int ALMOST_FULL_THRESHOLD = NUM_ENTRIES,
		parameter int ALMOST_EMPTY_THRESHOLD = 1
	)
	(
		input wire clk,
		input wire reset,
		input wire flush_en,
		output logic full,
		output logic almost_full,
		input wire enqueue_en,
		input wire logic [DATA_WIDTH - 1:0] value_i,
		output logic empty,
		output logic almost_empty,
		input wire dequeue_en,
		output logic [DATA_WIDTH - 1:0] value_o
	);

	// Read and write pointers into the circular buffer
	// They wrap on overflow, which is why the depth is a power of two
	logic [$clog2(NUM_ENTRIES) - 1:0] head;
	logic [$clog2(NUM_ENTRIES) - 1:0] tail;

	// Occupancy needs one more bit than the pointers to tell full from empty
	logic [$clog2(NUM_ENTRIES):0] count;

	// Entry storage
	logic [DATA_WIDTH - 1:0] data[NUM_ENTRIES];

	// All flags come straight from the count
	// They change right after the edge that changes the count
	assign almost_full = count >= ALMOST_FULL_THRESHOLD;
	assign almost_empty = count <= ALMOST_EMPTY_THRESHOLD;
	assign full = count == NUM_ENTRIES;
	assign empty = count == 0;

	// Show-ahead output
	// The head entry is visible without a read strobe
	assign value_o = data[head];

	// Pointer and count state
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else if (flush_en)
		begin
			// Flush drops everything and wins over a push or pop at the same edge
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			if (enqueue_en)
				tail <= tail + 1'b1;

			if (dequeue_en)
				head <= head + 1'b1;

			// A push and a pop together leave the occupancy unchanged
			if (enqueue_en && !dequeue_en)
				count <= count + 1'b1;
			else if (dequeue_en && !enqueue_en)
				count <= count - 1'b1;
		end
	end

	// Entry write
	// Nothing is stored at an edge that flushes the queue
	always_ff @(posedge clk)
	begin
		if (enqueue_en && !flush_en)
			data[tail] <= value_i;
	end

endmodule

`default_nettype wire

// File: verilog/l2_queue_if.sv
// Head view of one request queue; dequeue is a plain strobe and is only legal while empty is low
`timescale 1ns/10ps
`default_nettype none

interface l2_queue_if;
	import l2_types_pkg::*;

	// Queue is empty, so head holds no valid request
	logic empty;

	// Oldest request in the queue
	// It is valid in the same cycle as !empty
	queue_entry_t head;

	// Pops the head at the next clock edge
	logic dequeue;

	// The FIFO side shows its head and takes the pop
	modport queue
	(
		output empty,
		output head,
		input dequeue
	);

	// The arbiter side looks at the head and decides on the pop
	modport arbiter
	(
		input empty,
		input head,
		output dequeue
	);

endinterface

`default_nettype wire

// File: verilog/l2_types_pkg.sv
// Vector types of the request path; queue entries pack as {address, data, store} with store in bit 0
`default_nettype none

package l2_types_pkg;

	// Cache-line address as issued to the memory side
	typedef logic [l2_config_pkg::ADDR_WIDTH - 1:0] l2_addr_t;

	// Store data that the memory side ignores on loads
	typedef logic [l2_config_pkg::DATA_WIDTH - 1:0] l2_data_t;

	// Index of a requesting core
	// One bit while there are two cores
	typedef logic [$clog2(l2_config_pkg::NUM_PORTS) - 1:0] l2_port_t;

	// One request as the queue stores it
	// Kept as a flat vector so the FIFO can stay generic
	typedef logic [l2_config_pkg::ENTRY_WIDTH - 1:0] queue_entry_t;

endpackage

`default_nettype wire

// File: verilog/l2_config_pkg.sv
// Sizes for a two-core request path; QUEUE_DEPTH must stay a power of two and STALL_THRESHOLD below it
`default_nettype none

package l2_config_pkg;

	// Number of cores that share the cache request path
	localparam int NUM_PORTS = 2;

	// Entries per request queue
	// The FIFO pointers wrap by overflow, so this must be a power of two
	localparam int QUEUE_DEPTH = 8;

	// A core stops enqueuing once its queue holds this many entries
	// The gap to QUEUE_DEPTH absorbs two requests already in the core pipeline
	localparam int STALL_THRESHOLD = 6;

	// Cache-line address and store data widths
	localparam int ADDR_WIDTH = 26;
	localparam int DATA_WIDTH = 32;

	// A queue entry holds the address, the store data and one store flag
	localparam int ENTRY_WIDTH = ADDR_WIDTH + DATA_WIDTH + 1;

endpackage

`default_nettype wire
